// ==== verilog/lib_arbiter_pkg.sv ====
/*
 * Shared sizes and types for the two-level matrix arbiter.
 * Modules import it inside their body and use scoped names in port lists.
 * The requester matrix is lvl_rows by lvl_cols, stored row-major in one flat vector.
 */

package lib_arbiter_pkg;

    // ----------------------------------------
    // Matrix geometry
    // ----------------------------------------
    localparam int lvl_rows    = 4;                       // Requester rows
    localparam int lvl_cols    = 4;                       // Requester columns per row
    localparam int lvl_row_add = 2;                       // Row index width
    localparam int lvl_col_add = 2;                       // Column index width
    localparam int lvl_req     = lvl_rows * lvl_cols;     // Flat request vector width

    // ----------------------------------------
    // Wishbone side
    // ----------------------------------------
    localparam int wb_adr_w = lvl_row_add + lvl_col_add;  // Row in upper bits, column below
    localparam int wb_dat_w = 8;                          // One-hot column, zero-extended

    // Bus stage FSM, one write outstanding at most
    typedef enum logic [0:0]
    {
        WB_IDLE = 1'b0,                                   // Waiting for a grant
        WB_BUSY = 1'b1                                    // Cycle open, waiting for ack
    } wb_state_e;

endpackage

// ==== verilog/priority_arb.sv ====
/*
 * Fixed-priority arbiter, combinational.
 * Grants the lowest-index active request as a one-hot vector.
 * Used by both the row and the column round-robin stages.
 */
`timescale 1ns/1ps

module priority_arb
#(
    parameter int n_req = 4                       // Number of request lines
)
(
    input  logic [n_req-1:0] req_i,               // Active requests
    output logic [n_req-1:0] gnt_o                // One-hot grant, zero when idle
);

    logic found;                                  // Lower bit already granted

    always_comb
    begin
        gnt_o = '0;
        found = 1'b0;
        for (int i = 0; i < n_req; i++)           // Bit 0 has highest priority
        begin
            if (req_i[i] && !found)
            begin
                gnt_o[i] = 1'b1;
                found    = 1'b1;
            end
        end
    end

endmodule

// ==== verilog/row_arbiter.sv ====
/*
 * Round-robin row selection for the requester matrix.
 * Holds one row until the column stage releases it, then moves to the next
 * pending row above it, wrapping around. Each new row gets a refresh pulse
 * so the column mask reopens before any grant from that row.
 */
`timescale 1ns/1ps

module row_arbiter
(
    input  logic                                   clk_i,
    input  logic                                   reset_i,
    input  logic [lib_arbiter_pkg::lvl_req-1:0]     req_i,         // Flat request matrix
    input  logic                                   advance_i,     // Row done and bus ready
    output logic [lib_arbiter_pkg::lvl_row_add-1:0] row_sel_o,     // Selected row index
    output logic [lib_arbiter_pkg::lvl_cols-1:0]    row_req_o,     // Requests of that row
    output logic                                   row_valid_o,   // Row may be granted
    output logic                                   col_refresh_o  // Reopen column mask
);

    import lib_arbiter_pkg::*;

    logic [lvl_rows-1:0]    row_pend;       // Row has any request
    logic [lvl_rows-1:0]    row_mask_q;     // Rows above the last selected one
    logic [lvl_rows-1:0]    cand;           // Pending rows still ahead in this round
    logic [lvl_rows-1:0]    cand_gnt;
    logic [lvl_rows-1:0]    wrap_gnt;
    logic [lvl_rows-1:0]    pick_oh;        // Next row, one-hot
    logic [lvl_row_add-1:0] pick_idx;
    logic                   live_q;         // A row is currently selected
    logic                   refresh_q;
    logic                   load;

    // ----------------------------------------
    // Next-row search
    // ----------------------------------------
    always_comb
    begin
        for (int r = 0; r < lvl_rows; r++)
        begin
            row_pend[r] = |req_i[r*lvl_cols +: lvl_cols];   // OR-reduce each row
        end
    end

    assign cand = row_pend & row_mask_q;

    priority_arb #(.n_req(lvl_rows)) u_cand_arb (.req_i(cand), .gnt_o(cand_gnt));
    priority_arb #(.n_req(lvl_rows)) u_wrap_arb (.req_i(row_pend), .gnt_o(wrap_gnt));

    assign pick_oh = (|cand) ? cand_gnt : wrap_gnt;          // Wrap when nothing is above

    always_comb
    begin
        pick_idx = '0;
        for (int r = 0; r < lvl_rows; r++)
        begin
            if (pick_oh[r])
            begin
                pick_idx = r[lvl_row_add-1:0];
            end
        end
    end

    // Search when idle, or on release once the refresh cycle is over
    assign load = ~live_q | (advance_i & ~refresh_q);

    // ----------------------------------------
    // Row state
    // ----------------------------------------
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            row_sel_o  <= '0;
            row_mask_q <= '1;                                // First round starts at row 0
            live_q     <= 1'b0;
            refresh_q  <= 1'b0;
        end
        else
        begin
            refresh_q <= 1'b0;
            if (load)
            begin
                live_q <= |row_pend;                         // Drop out when nothing pending
                if (|row_pend)
                begin
                    row_sel_o  <= pick_idx;
                    row_mask_q <= ~((pick_oh << 1) - {{(lvl_rows-1){1'b0}}, 1'b1});
                    refresh_q  <= 1'b1;
                end
            end
        end
    end

    assign row_req_o     = req_i[row_sel_o*lvl_cols +: lvl_cols];
    assign row_valid_o   = live_q & ~refresh_q;              // Hidden while the mask reopens
    assign col_refresh_o = refresh_q;

endmodule

// ==== verilog/column_arbiter.sv ====
/*
 * Masked round-robin grant over the columns of the selected row.
 * Each enable registers one grant and closes that column and all below it.
 * Group release rises when no open column is requesting; refresh reopens
 * the whole row. Works for any column count.
 */
`timescale 1ns/1ps

module column_arbiter
#(
    parameter int lvl_cols = lib_arbiter_pkg::lvl_cols      // Columns in one row
)
(
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        enable_i,           // Take the next grant
    input  logic                        refresh_i,          // Reopen every column
    input  logic [lvl_cols-1:0]         req_i,              // Requests of the selected row
    output logic [lvl_cols-1:0]         gnt_o,              // Registered one-hot grant
    output logic [$clog2(lvl_cols)-1:0] yadd_o,             // Index of the granted column
    output logic                        grp_release_o       // Row has nothing left open
);

    logic [lvl_cols-1:0] mask_q;            // Thermometer of still-open columns
    logic [lvl_cols-1:0] mask_req;
    logic [lvl_cols-1:0] mask_gnt;
    logic [lvl_cols-1:0] mask_nxt;

    // ----------------------------------------
    // Masked request and next mask
    // ----------------------------------------
    assign mask_req      = req_i & mask_q;
    assign grp_release_o = ~(|mask_req);

    // Keep only the bits above the grant; a grant on the top bit closes the row
    assign mask_nxt = ~((mask_gnt << 1) - {{(lvl_cols-1){1'b0}}, 1'b1});

    priority_arb #(.n_req(lvl_cols)) u_mask_arb
    (
        .req_i (mask_req),
        .gnt_o (mask_gnt)
    );

    // ----------------------------------------
    // Grant register
    // ----------------------------------------
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            mask_q <= '1;                   // All columns open
            gnt_o  <= '0;
        end
        else if (refresh_i)                 // New row wins over a grant
        begin
            mask_q <= '1;
        end
        else if (enable_i)
        begin
            mask_q <= mask_nxt;             // Same edge as the grant
            gnt_o  <= mask_gnt;
        end
    end

    // One-hot to index
    always_comb
    begin
        yadd_o = '0;
        for (int i = 0; i < lvl_cols; i++)
        begin
            if (gnt_o[i])
            begin
                yadd_o = i[$clog2(lvl_cols)-1:0];
            end
        end
    end

endmodule

// ==== verilog/grant_wb_master.sv ====
/*
 * Bus stage of the arbiter. Each grant becomes one Wishbone classic
 * single write: row and column form the address, the one-hot column the data.
 * The cycle stays open until ack; ready_o tells the grant stages to wait.
 */
`timescale 1ns/1ps

module grant_wb_master
(
    input  logic                                   clk_i,
    input  logic                                   reset_i,
    input  logic                                   gnt_valid_i,  // Grant registered last cycle
    input  logic [lib_arbiter_pkg::lvl_cols-1:0]    gnt_i,        // One-hot column
    input  logic [lib_arbiter_pkg::lvl_col_add-1:0] yadd_i,       // Column index
    input  logic [lib_arbiter_pkg::lvl_row_add-1:0] xadd_i,       // Row index
    output logic                                   ready_o,      // Free for a new grant
    output logic                                   wb_cyc_o,
    output logic                                   wb_stb_o,
    output logic                                   wb_we_o,
    output logic [lib_arbiter_pkg::wb_adr_w-1:0]    wb_adr_o,
    output logic [lib_arbiter_pkg::wb_dat_w-1:0]    wb_dat_o,
    input  logic                                   wb_ack_i
);

    import lib_arbiter_pkg::*;

    wb_state_e             state_q;
    logic [wb_adr_w-1:0]   adr_q;          // Held for the whole cycle
    logic [wb_dat_w-1:0]   dat_q;

    // ----------------------------------------
    // Bus FSM
    // ----------------------------------------
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q <= WB_IDLE;
        end
        else
        begin
            case (state_q)
                WB_IDLE:
                begin
                    if (gnt_valid_i)
                        state_q <= WB_BUSY;         // Open the cycle next edge
                end
                WB_BUSY:
                begin
                    if (wb_ack_i)
                        state_q <= WB_IDLE;         // Single beat, close on ack
                end
                default: state_q <= WB_IDLE;
            endcase
        end
    end

    // Address and data captured with the grant
    always_ff @(posedge clk_i)
    begin
        if (state_q == WB_IDLE && gnt_valid_i)
        begin
            adr_q <= {xadd_i, yadd_i};
            dat_q <= wb_dat_w'(gnt_i);
        end
    end

    assign wb_cyc_o = (state_q == WB_BUSY);
    assign wb_stb_o = (state_q == WB_BUSY);     // Rises and falls with cyc
    assign wb_we_o  = (state_q == WB_BUSY);     // Writes only
    assign wb_adr_o = adr_q;
    assign wb_dat_o = dat_q;
    assign ready_o  = (state_q == WB_IDLE) & ~gnt_valid_i;   // Low while a capture is due

endmodule

// ==== verilog/matrix_arbiter_top.sv ====
/*
 * Two-level round-robin arbiter for the requester matrix with a Wishbone
 * write port. Row select, registered column grant and bus write run as a
 * three-stage pipeline; ack back-pressure freezes row and column state.
 */
`timescale 1ns/1ps

module matrix_arbiter_top
(
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic [lib_arbiter_pkg::lvl_req-1:0]  req_i,       // Bit r*lvl_cols+c
    input  logic                                wb_ack_i,
    output logic                                wb_cyc_o,
    output logic                                wb_stb_o,
    output logic                                wb_we_o,
    output logic [lib_arbiter_pkg::wb_adr_w-1:0] wb_adr_o,
    output logic [lib_arbiter_pkg::wb_dat_w-1:0] wb_dat_o
);

    import lib_arbiter_pkg::*;

    logic [lvl_row_add-1:0] row_sel;
    logic [lvl_cols-1:0]    row_req;
    logic                   row_valid;
    logic                   col_refresh;
    logic                   grp_release;
    logic [lvl_cols-1:0]    gnt;
    logic [lvl_col_add-1:0] yadd;
    logic                   stage_ready;     // Bus stage can take a grant
    logic                   col_enable;
    logic                   gnt_valid;       // Enable, one cycle late
    logic [lvl_row_add-1:0] xadd_q;          // Row of the grant in flight

    // A released row is not granted; it advances instead
    assign col_enable = row_valid & stage_ready & ~grp_release;

    row_arbiter u_row_arb
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .req_i         (req_i),
        .advance_i     (grp_release & stage_ready),
        .row_sel_o     (row_sel),
        .row_req_o     (row_req),
        .row_valid_o   (row_valid),
        .col_refresh_o (col_refresh)
    );

    column_arbiter #(.lvl_cols(lvl_cols)) u_col_arb
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (col_enable),
        .refresh_i     (col_refresh),
        .req_i         (row_req),
        .gnt_o         (gnt),
        .yadd_o        (yadd),
        .grp_release_o (grp_release)
    );

    // ----------------------------------------
    // Grant to bus stage
    // ----------------------------------------
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            gnt_valid <= 1'b0;
        else
            gnt_valid <= col_enable;         // Lines up with the registered grant
    end

    always_ff @(posedge clk_i)
    begin
        if (col_enable)
            xadd_q <= row_sel;               // Row may move before the capture
    end

    grant_wb_master u_wb_master
    (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .gnt_valid_i (gnt_valid),
        .gnt_i       (gnt),
        .yadd_i      (yadd),
        .xadd_i      (xadd_q),
        .ready_o     (stage_ready),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_we_o     (wb_we_o),
        .wb_adr_o    (wb_adr_o),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_i    (wb_ack_i)
    );

endmodule

// ==== test/matrix_arbiter_properties.sv ====
/*
 * Assertions on the Wishbone side of the bus stage, bound into
 * grant_wb_master from the testbench. Covers the cyc/stb handshake,
 * address and data hold under back-pressure and the one-hot data encoding.
 */
`timescale 1ns/1ps

module matrix_arbiter_properties
(
    input logic                                  clk_i,
    input logic                                  reset_i,
    input lib_arbiter_pkg::wb_state_e            state_i,   // Bus FSM state
    input logic                                  cyc_i,
    input logic                                  stb_i,
    input logic                                  ack_i,
    input logic [lib_arbiter_pkg::wb_adr_w-1:0]  adr_i,
    input logic [lib_arbiter_pkg::wb_dat_w-1:0]  dat_i
);

    import lib_arbiter_pkg::*;

    // ----------------------------------------
    // Handshake
    // ----------------------------------------
    a_stb_cyc: assert property (@(posedge clk_i) disable iff (reset_i) stb_i |-> cyc_i)
        else $error("stb high while cyc is low");

    a_open: assert property (@(posedge clk_i) disable iff (reset_i)
        (state_i == WB_BUSY && !ack_i) |=> cyc_i)          // Open cycle waits for ack
        else $error("cycle closed before ack");

    a_close: assert property (@(posedge clk_i) disable iff (reset_i)
        (stb_i && ack_i) |=> !cyc_i)                       // Single beat per cycle
        else $error("cycle still open after ack");

    // ----------------------------------------
    // Address and data
    // ----------------------------------------
    a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        (stb_i && !ack_i) |=> ($stable(adr_i) && $stable(dat_i)))
        else $error("address or data moved while waiting for ack");

    a_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        stb_i |-> ($onehot(dat_i) && dat_i == (wb_dat_w'(1) << adr_i[lvl_col_add-1:0])))
        else $error("data is not the one-hot column of the address");

endmodule

// ==== test/matrix_arbiter_tb.sv ====
/*
 * Testbench for the matrix arbiter. Reads scenarios from the data file,
 * acts as the Wishbone sink with a per-scenario ack delay and checks every
 * write against a round-robin order worked out from the request matrix.
 */
`timescale 1ns/1ps

module matrix_arbiter_tb;

    import lib_arbiter_pkg::*;

    logic                clk;
    logic                reset;
    logic [lvl_req-1:0]  req;                   // Driven request matrix
    logic                wb_ack;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [wb_adr_w-1:0] wb_adr;
    logic [wb_dat_w-1:0] wb_dat;

    logic [lvl_req-1:0]  scen_req[$];           // One entry per scenario line
    logic [lvl_req-1:0]  scen_late[$];          // Raised at the first ack
    int                  scen_delay[$];
    int                  scen_count[$];
    logic [wb_adr_w-1:0] exp_adr[$];            // Expected write order
    int                  last_row    = -1;      // No row served after reset
    int                  val_errs    = 0;
    int                  other_errs  = 0;
    int                  cycle_cnt   = 0;
    int                  cycle_limit = 1000;

    matrix_arbiter_top DUT
    (
        .clk_i    (clk),
        .reset_i  (reset),
        .req_i    (req),
        .wb_ack_i (wb_ack),
        .wb_cyc_o (wb_cyc),
        .wb_stb_o (wb_stb),
        .wb_we_o  (wb_we),
        .wb_adr_o (wb_adr),
        .wb_dat_o (wb_dat)
    );

    bind grant_wb_master matrix_arbiter_properties u_props
    (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .state_i (state_q),
        .cyc_i   (wb_cyc_o),
        .stb_i   (wb_stb_o),
        .ack_i   (wb_ack_i),
        .adr_i   (wb_adr_o),
        .dat_i   (wb_dat_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;                  // 10 ns period
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // Scenario file
    // ----------------------------------------
    task automatic read_scenarios();
        int                 fd;
        int                 n;
        string              line;
        logic [lvl_req-1:0] r;
        logic [lvl_req-1:0] l;
        int                 d;
        int                 c;
        fd = $fopen("test/arbiter_input.txt", "r");
        if (fd == 0)
        begin
            other_errs++;
            $display("cannot open test/arbiter_input.txt");
            return;
        end
        while ($fgets(line, fd) > 0)
        begin
            if (line.len() > 1 && line.getc(0) != "#")      // Skip column notes
            begin
                n = $sscanf(line, "%h %h %d %d", r, l, d, c);
                if (n == 4)
                begin
                    scen_req.push_back(r);
                    scen_late.push_back(l);
                    scen_delay.push_back(d);
                    scen_count.push_back(c);
                end
            end
        end
        $fclose(fd);
        if (scen_req.size() == 0)
        begin
            other_errs++;
            $display("no scenarios found in the data file");
        end
    endtask

    // ----------------------------------------
    // Expected order, row-major round robin
    // ----------------------------------------
    task automatic build_expected(input logic [lvl_req-1:0] req_v,
                                  input logic [lvl_req-1:0] late_v);
        logic [lvl_req-1:0]  pend;
        logic [lvl_cols-1:0] col_open;          // Columns still ahead in held row
        logic                first;
        int                  row;
        int                  col;
        int                  r;
        pend     = req_v;
        col_open = '0;                          // No row held at the start
        first    = 1'b1;
        row      = 0;
        while (pend != '0)
        begin
            if ((pend[row*lvl_cols +: lvl_cols] & col_open) == '0)
            begin
                for (int k = lvl_rows; k >= 1; k--)          // Nearest pending row wins
                begin
                    r = (last_row + k) % lvl_rows;
                    if (pend[r*lvl_cols +: lvl_cols] != '0)
                    begin
                        row = r;
                    end
                end
                last_row = row;
                col_open = '1;                  // Fresh visit reopens all columns
            end
            col = lvl_cols;
            for (int c = lvl_cols - 1; c >= 0; c--)
            begin
                if (pend[row*lvl_cols + c] && col_open[c])
                begin
                    col = c;                    // Lowest open column
                end
            end
            exp_adr.push_back(wb_adr_w'(row * lvl_cols + col));
            pend[row*lvl_cols + col] = 1'b0;
            for (int c = 0; c < lvl_cols; c++)
            begin
                col_open[c] = (c > col);        // Served column and below close
            end
            if (first)
            begin
                pend = pend | late_v;
            end
            first = 1'b0;
        end
    endtask

    // ----------------------------------------
    // One scenario with the sink in the loop
    // ----------------------------------------
    task automatic run_scenario(input int idx);
        logic [wb_adr_w-1:0] exp_a;
        logic [wb_dat_w-1:0] exp_d;
        logic [lvl_req-1:0]  served;
        int                  done;
        int                  quiet;
        int                  wait_cnt;
        exp_adr.delete();
        build_expected(scen_req[idx], scen_late[idx]);
        if (exp_adr.size() != scen_count[idx])
        begin
            other_errs++;
            $display("scenario %0d: worked-out order has %0d writes but the file expects %0d",
                     idx, exp_adr.size(), scen_count[idx]);
        end
        done     = 0;
        quiet    = 0;
        wait_cnt = 0;
        @(posedge clk);
        req <= scen_req[idx];
        while (done < scen_count[idx] || quiet < 8)         // Quiet window catches extras
        begin
            @(posedge clk);
            quiet++;
            if (wb_stb && wb_ack)                           // Write completes on this edge
            begin
                if (exp_adr.size() == 0)
                begin
                    other_errs++;
                    $display("unexpected write to address 0x%h in scenario %0d", wb_adr, idx);
                end
                else
                begin
                    exp_a = exp_adr.pop_front();
                    exp_d = '0;
                    exp_d[exp_a[lvl_col_add-1:0]] = 1'b1;
                    if (wb_adr !== exp_a)
                    begin
                        val_errs++;
                        $display("error wb_adr_o: got 0x%h expected 0x%h", wb_adr, exp_a);
                    end
                    if (wb_dat !== exp_d)
                    begin
                        val_errs++;
                        $display("error wb_dat_o: got 0x%h expected 0x%h", wb_dat, exp_d);
                    end
                    if (wb_we !== 1'b1 || wb_cyc !== 1'b1)
                    begin
                        other_errs++;
                        $display("write at address 0x%h without cyc or we", wb_adr);
                    end
                end
                served         = '0;
                served[wb_adr] = 1'b1;
                req      <= (req & ~served) | ((done == 0) ? scen_late[idx] : '0);
                wb_ack   <= 1'b0;
                wait_cnt = 0;
                quiet    = 0;
                done++;
            end
            else if (wb_stb)
            begin
                quiet = 0;
                if (wait_cnt >= scen_delay[idx])
                begin
                    wb_ack <= 1'b1;
                end
                else
                begin
                    wait_cnt++;                             // Wait states before ack
                end
            end
        end
        if (done != scen_count[idx])
        begin
            val_errs++;
            $display("error write count: got 0x%h expected 0x%h", done, scen_count[idx]);
        end
    endtask

    initial
    begin
        reset  = 1'b1;
        req    = '0;
        wb_ack = 1'b0;
        read_scenarios();
        cycle_limit = 50;
        foreach (scen_req[i])
        begin
            cycle_limit += 40 + scen_count[i] * (scen_delay[i] + 8);
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        if (wb_cyc || wb_stb || wb_we)
        begin
            other_errs++;
            $display("bus is active right after reset");
        end
        foreach (scen_req[i])
        begin
            run_scenario(i);
        end
        $display("checks done: %0d value errors, %0d other errors", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== test/arbiter_input.txt ====
# req_hex late_hex ack_delay write_count
# Hex digit r of req is row r, bit c of it is column c; late bits rise at the first ack
0000 0000 0 0
0001 0000 0 1
0400 0000 2 1
00F0 0000 1 4
8000 0000 3 1
0F0F 0000 0 8
FFFF 0000 1 16
1248 0000 5 4
00E0 0010 2 4
0C00 0300 4 4
5A5A 0000 3 8
000F 00F0 0 8
3000 0000 5 2
8421 0000 1 4
F001 0000 2 5
0000 0000 0 0

// ==== sources.f ====
verilog/lib_arbiter_pkg.sv
verilog/priority_arb.sv
verilog/row_arbiter.sv
verilog/column_arbiter.sv
verilog/grant_wb_master.sv
verilog/matrix_arbiter_top.sv
test/matrix_arbiter_properties.sv
test/matrix_arbiter_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the matrix arbiter testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module matrix_arbiter_tb \
    -f sources.f -o matrix_arbiter_sim \
    && ./obj_dir/matrix_arbiter_sim > sim.log 2>&1 \
    || echo "Build or simulation stopped with an error" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || exit 1
exit 0
